//--- verilog/sram_params.svh
// ####################################################################
// Bus and memory size macros for the half-width SRAM controller
// AHB side is 32 bits wide, the SRAM side carries one halfword
// ####################################################################

`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// AHB bus widths
`define SRAM_W_DATA 32
`define SRAM_W_ADDR 32

// SRAM geometry, depth counted in halfwords
`define SRAM_DEPTH 2048
`define SRAM_W_SRAM_ADDR 11

// SRAM data pins carry half an AHB word
`define SRAM_W_SRAM_DATA (`SRAM_W_DATA / 2)

`endif

//--- verilog/ahb_pkg.sv
// ####################################################################
// AHB-Lite side types: address, data word, HTRANS and HSIZE codes
// ####################################################################

`include "sram_params.svh"

package ahb_pkg;

	typedef logic [`SRAM_W_ADDR-1:0] ahb_addr_t;
	typedef logic [`SRAM_W_DATA-1:0] ahb_data_t;

	// Transfer type, bit 1 set means an active transfer
	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_BUSY   = 2'b01,
		HTRANS_NONSEQ = 2'b10,
		HTRANS_SEQ    = 2'b11
	} ahb_trans_e;

	// Transfer size, only up to the bus width
	typedef enum logic [2:0] {
		HSIZE_BYTE = 3'b000,
		HSIZE_HALF = 3'b001,
		HSIZE_WORD = 3'b010
	} ahb_size_e;

endpackage

//--- verilog/sram_pkg.sv
// ####################################################################
// SRAM side types and the access controller state encoding
// ####################################################################

`include "sram_params.svh"

package sram_pkg;

	// Halfword address at the SRAM pins
	typedef logic [`SRAM_W_SRAM_ADDR-1:0] sram_addr_t;

	// One halfword on the data pins
	typedef logic [`SRAM_W_SRAM_DATA-1:0] sram_data_t;

	// Active-low byte strobes, bit 0 is the low byte
	typedef logic [`SRAM_W_SRAM_DATA/8-1:0] sram_byte_t;

	// State names the current data phase
	typedef enum logic [1:0] {
		ST_IDLE    = 2'b00,
		ST_SHORT   = 2'b01,
		ST_WORD_LO = 2'b10,
		ST_WORD_HI = 2'b11
	} sram_state_e;

endpackage

//--- verilog/sram_access_fsm.sv
// ####################################################################
// AHB address phase decode and SRAM control sequencing
// Byte and halfword transfers take one SRAM cycle, words take two
// with the low halfword first and a wait state on the bus
// ####################################################################

`include "sram_params.svh"

module sram_access_fsm (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 hready,
	input  ahb_pkg::ahb_addr_t   haddr,
	input  ahb_pkg::ahb_trans_e  htrans,
	input  ahb_pkg::ahb_size_e   hsize,
	input  logic                 hwrite,
	output logic                 hready_resp,
	output sram_pkg::sram_addr_t sram_addr,
	output logic                 sram_ce_n,
	output logic                 sram_oe_n,
	output sram_pkg::sram_byte_t sram_byte_n,
	output logic                 write_next,
	output logic                 capture_lo,
	output logic                 word_phase
);

	import ahb_pkg::*;
	import sram_pkg::*;

	sram_state_e state;
	sram_byte_t  byte_dec;
	logic        aphase_valid;
	logic        aphase_word;

	assign aphase_valid = hready && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);
	assign aphase_word = (hsize == HSIZE_WORD);

	// Byte strobes for the addressed lanes of the selected halfword
	always_comb begin
		case (hsize)
			HSIZE_BYTE: byte_dec = haddr[0] ? 2'b01 : 2'b10;
			default:    byte_dec = 2'b00;
		endcase
	end

	// Low half of a word read sits on the pins during WORD_LO
	assign capture_lo = (state == ST_WORD_LO);

	// New write, or second half of a word write (oe_n high with ce_n low)
	assign write_next = (aphase_valid && hwrite) ||
		(state == ST_WORD_LO && sram_oe_n);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			sram_addr <= '0;
			sram_ce_n <= 1'b1;
			sram_oe_n <= 1'b1;
			sram_byte_n <= '1;
			hready_resp <= 1'b1;
			word_phase <= 1'b0;
		end else if (hready) begin
			if (aphase_valid) begin
				state <= aphase_word ? ST_WORD_LO : ST_SHORT;
				sram_addr <= haddr[1 +: `SRAM_W_SRAM_ADDR];
				sram_ce_n <= 1'b0;
				sram_oe_n <= hwrite;
				sram_byte_n <= byte_dec;
				hready_resp <= !aphase_word;
				word_phase <= aphase_word;
			end else begin
				// Idle or busy, park the SRAM
				state <= ST_IDLE;
				sram_ce_n <= 1'b1;
				sram_oe_n <= 1'b1;
				sram_byte_n <= '1;
				hready_resp <= 1'b1;
				word_phase <= 1'b0;
			end
		end else if (state == ST_WORD_LO) begin
			// Move on to the odd halfword and release the bus next cycle
			state <= ST_WORD_HI;
			sram_addr[0] <= 1'b1;
			hready_resp <= 1'b1;
		end
	end

endmodule

//--- verilog/sram_data_lane.sv
// ####################################################################
// SRAM data path: write halfword select, tristate pins, read buffer
// and assembly of the 32-bit read word from two halfwords
// ####################################################################

`include "sram_params.svh"

module sram_data_lane (
	input  logic                 clk,
	input  logic                 rst_n,
	input  ahb_pkg::ahb_data_t   hwdata,
	input  logic                 addr_hi,
	input  logic                 sram_oe_n,
	input  logic                 capture_lo,
	input  logic                 word_phase,
	output ahb_pkg::ahb_data_t   hrdata,
	inout  wire sram_pkg::sram_data_t sram_dq
);

	import sram_pkg::*;

	sram_data_t wdata_half;
	sram_data_t rdata_pin;
	sram_data_t rdata_buf;

	// Odd halfword address takes the upper byte lanes of hwdata
	assign wdata_half = addr_hi ?
		hwdata[`SRAM_W_DATA-1 -: `SRAM_W_SRAM_DATA] :
		hwdata[`SRAM_W_SRAM_DATA-1:0];

	// Pins are driven whenever the SRAM outputs are off
	assign sram_dq = sram_oe_n ? wdata_half : 'z;

	// Zero the read path when nothing is being read
	assign rdata_pin = sram_dq & {`SRAM_W_SRAM_DATA{~sram_oe_n}};

	// Hold the low half of a word until the high half arrives
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata_buf <= '0;
		end else if (capture_lo) begin
			rdata_buf <= rdata_pin;
		end
	end

	// Narrow reads show up in both halves, so either byte lane works
	assign hrdata = {rdata_pin, word_phase ? rdata_buf : rdata_pin};

endmodule

//--- verilog/sram_we_strobe.sv
// ####################################################################
// Half-cycle SRAM write enable from a rising/falling flop pair
// Low while clk is high in the cycle after write_next
// ####################################################################

module sram_we_strobe (
	input  logic clk,
	input  logic rst_n,
	input  logic write_next,
	output logic sram_we_n
);

	logic we_rise;
	logic we_fall;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			we_rise <= 1'b1;
		end else begin
			we_rise <= !write_next;
		end
	end

	// Falling edge side always returns the strobe high
	always_ff @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			we_fall <= 1'b1;
		end else begin
			we_fall <= 1'b1;
		end
	end

	// SRAM latches data on the mid-cycle rising edge of we_n
	assign sram_we_n = clk ? we_rise : we_fall;

endmodule

//--- verilog/ahb_async_sram_halfwidth.sv
// ####################################################################
// AHB-Lite slave for an asynchronous SRAM of half the bus width
// Joins the access FSM, the data lane and the write strobe
// ####################################################################

module ahb_async_sram_halfwidth (
	input  logic                 clk,
	input  logic                 rst_n,

	// AHB-Lite slave
	input  logic                 hready,
	output logic                 hready_resp,
	input  ahb_pkg::ahb_addr_t   haddr,
	input  logic                 hwrite,
	input  ahb_pkg::ahb_trans_e  htrans,
	input  ahb_pkg::ahb_size_e   hsize,
	input  ahb_pkg::ahb_data_t   hwdata,
	output ahb_pkg::ahb_data_t   hrdata,

	// Async SRAM
	output sram_pkg::sram_addr_t sram_addr,
	inout  wire sram_pkg::sram_data_t sram_dq,
	output logic                 sram_ce_n,
	output logic                 sram_oe_n,
	output logic                 sram_we_n,
	output sram_pkg::sram_byte_t sram_byte_n
);

	logic write_next;
	logic capture_lo;
	logic word_phase;

	sram_access_fsm u_fsm (
		.clk         (clk),
		.rst_n       (rst_n),
		.hready      (hready),
		.haddr       (haddr),
		.htrans      (htrans),
		.hsize       (hsize),
		.hwrite      (hwrite),
		.hready_resp (hready_resp),
		.sram_addr   (sram_addr),
		.sram_ce_n   (sram_ce_n),
		.sram_oe_n   (sram_oe_n),
		.sram_byte_n (sram_byte_n),
		.write_next  (write_next),
		.capture_lo  (capture_lo),
		.word_phase  (word_phase)
	);

	// Lowest SRAM address bit picks the hwdata half
	sram_data_lane u_lane (
		.clk        (clk),
		.rst_n      (rst_n),
		.hwdata     (hwdata),
		.addr_hi    (sram_addr[0]),
		.sram_oe_n  (sram_oe_n),
		.capture_lo (capture_lo),
		.word_phase (word_phase),
		.hrdata     (hrdata),
		.sram_dq    (sram_dq)
	);

	sram_we_strobe u_we (
		.clk        (clk),
		.rst_n      (rst_n),
		.write_next (write_next),
		.sram_we_n  (sram_we_n)
	);

endmodule

//--- bench/async_sram_model.sv
// ####################################################################
// Behavioral asynchronous SRAM, 16 bits wide with byte strobes
// Writes land on the rising edge of we_n, reads are combinational
// ####################################################################

`include "sram_params.svh"

module async_sram_model (
	input  sram_pkg::sram_addr_t addr,
	inout  wire sram_pkg::sram_data_t dq,
	input  logic                 ce_n,
	input  logic                 oe_n,
	input  logic                 we_n,
	input  sram_pkg::sram_byte_t byte_n
);

	timeunit 1ns;
	timeprecision 100ps;

	import sram_pkg::*;

	sram_data_t mem [0:`SRAM_DEPTH-1];

	// Known content everywhere, different for every halfword
	initial begin
		for (int i = 0; i < `SRAM_DEPTH; i++) begin
			mem[i] = 16'h5a5a ^ {5'b0, i[10:0]};
		end
	end

	// Outputs on only while reading
	assign dq = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

	always @(posedge we_n) begin
		if (!ce_n) begin
			if (!byte_n[0])
				mem[addr][7:0] = dq[7:0];
			if (!byte_n[1])
				mem[addr][15:8] = dq[15:8];
		end
	end

endmodule

//--- bench/tb_ahb_sram.sv
// ####################################################################
// Testbench for the half-width SRAM AHB slave
// Pipelined AHB master replaying a case file against an SRAM model
// ####################################################################

module tb_ahb_sram;

	timeunit 1ns;
	timeprecision 100ps;

	import ahb_pkg::*;
	import sram_pkg::*;

	logic clk = 1'b0;
	logic rst_n;
	logic hready, hready_resp, hwrite;
	ahb_addr_t haddr;
	ahb_trans_e htrans;
	ahb_size_e hsize;
	ahb_data_t hwdata, hrdata;
	sram_addr_t sram_addr;
	wire sram_data_t sram_dq;
	logic sram_ce_n, sram_oe_n, sram_we_n;
	sram_byte_t sram_byte_n;

	logic [31:0] ops[$], addrs[$], sizes[$], wdatas[$], exps[$];
	logic [7:0] ref_mem [0:4095];
	int errors = 0;
	int checks = 0;
	int n_cases = 0;
	bit cases_loaded = 1'b0;

	always #4 clk = ~clk;
	assign hready = hready_resp;

	ahb_async_sram_halfwidth u_dut (
		.clk(clk), .rst_n(rst_n), .hready(hready), .hready_resp(hready_resp),
		.haddr(haddr), .hwrite(hwrite), .htrans(htrans), .hsize(hsize),
		.hwdata(hwdata), .hrdata(hrdata), .sram_addr(sram_addr), .sram_dq(sram_dq),
		.sram_ce_n(sram_ce_n), .sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n),
		.sram_byte_n(sram_byte_n)
	);

	async_sram_model u_sram (
		.addr(sram_addr), .dq(sram_dq), .ce_n(sram_ce_n), .oe_n(sram_oe_n),
		.we_n(sram_we_n), .byte_n(sram_byte_n)
	);

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error: %s actual 0x%08h expected 0x%08h at %0t", name, actual,
				expected, $time);
		end
	endtask

	task automatic load_cases();
		int fd;
		int code;
		string line;
		logic [31:0] v_op, v_addr, v_size, v_wd, v_exp;
		fd = $fopen("bench/sram_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file bench/sram_cases.txt");
			errors++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() > 1 && line[0] != "#") begin
				code = $sscanf(line, "%h %h %h %h %h", v_op, v_addr, v_size, v_wd, v_exp);
				if (code == 5) begin
					ops.push_back(v_op);
					addrs.push_back(v_addr);
					sizes.push_back(v_size);
					wdatas.push_back(v_wd);
					exps.push_back(v_exp);
				end
			end
		end
		$fclose(fd);
		n_cases = ops.size();
	endtask

	// Little-endian lanes, byte address bits [1:0] pick the hwdata lane
	task automatic ref_write(input logic [31:0] addr, input logic [1:0] size,
		input logic [31:0] data);
		logic [11:0] b;
		for (int k = 0; k < (1 << size); k++) begin
			b = (addr[11:0] & ~12'((1 << size) - 1)) + 12'(k);
			ref_mem[b] = data[8 * b[1:0] +: 8];
		end
	endtask

	// Narrow reads come back as the addressed halfword in both halves
	function automatic logic [31:0] ref_read(input logic [31:0] addr,
		input logic [1:0] size);
		logic [11:0] a;
		a = {addr[11:2], 2'b00};
		if (size == 2'd2)
			return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
		a = {addr[11:1], 1'b0};
		return {ref_mem[a + 1], ref_mem[a], ref_mem[a + 1], ref_mem[a]};
	endfunction

	task automatic drive_address(input int k);
		if (k >= n_cases || ops[k] == 0) begin
			htrans <= HTRANS_IDLE;
			haddr <= '0;
			hwrite <= 1'b0;
			hsize <= HSIZE_BYTE;
		end else begin
			htrans <= HTRANS_NONSEQ;
			haddr <= addrs[k];
			hwrite <= (ops[k] == 1);
			hsize <= ahb_size_e'(sizes[k][2:0]);
		end
	endtask

	task automatic finish_transfer(input int k, input int waits);
		logic [31:0] sram_exp;
		// Words end on the odd halfword, narrow transfers sit on haddr[11:1]
		sram_exp = (sizes[k] == 2) ? {21'b0, addrs[k][11:2], 1'b1} :
			{21'b0, addrs[k][11:1]};
		compare_value("sram_addr", sram_addr, sram_exp);
		if (ops[k] == 1) begin
			ref_write(addrs[k], sizes[k][1:0], wdatas[k]);
		end else begin
			compare_value("hrdata", hrdata, exps[k]);
			compare_value("hrdata_vs_ref", hrdata, ref_read(addrs[k], sizes[k][1:0]));
		end
		compare_value("hready_resp_low_cycles", waits, (sizes[k] == 2) ? 32'd1 : 32'd0);
	endtask

	initial begin
		int cur;
		int dp;
		int waits;
		bit rdy_prev;
		bit finished;
		rst_n = 1'b0;
		htrans = HTRANS_IDLE;
		haddr = '0;
		hwrite = 1'b0;
		hsize = HSIZE_BYTE;
		hwdata = '0;
		for (int j = 0; j < 2048; j++) begin
			ref_mem[2 * j] = 8'h5a ^ 8'(j);
			ref_mem[2 * j + 1] = 8'h5a ^ {5'b0, 3'(j >> 8)};
		end
		load_cases();
		cases_loaded = 1'b1;
		repeat (10) @(negedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		compare_value("sram_ce_n", sram_ce_n, 1);
		compare_value("sram_oe_n", sram_oe_n, 1);
		compare_value("sram_we_n", sram_we_n, 1);
		compare_value("sram_byte_n", sram_byte_n, 3);
		compare_value("hready_resp", hready_resp, 1);
		cur = -1;
		dp = -1;
		waits = 0;
		rdy_prev = 1'b1;
		finished = (n_cases == 0);
		while (!finished) begin
			@(negedge clk);
			// Last rising edge took the address on the bus
			if (rdy_prev) begin
				dp = cur;
				waits = 0;
				if (cur < n_cases)
					cur = cur + 1;
				drive_address(cur);
			end
			if (hready_resp) begin
				if (dp >= 0 && dp < n_cases && ops[dp] != 0)
					finish_transfer(dp, waits);
				hwdata <= (cur < n_cases && ops[cur] == 1) ? wdatas[cur] : '0;
				finished = (cur == n_cases);
			end else begin
				waits++;
			end
			rdy_prev = hready_resp;
		end
		repeat (2) @(negedge clk);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Reset, then at most four cycles per case, plus slack
	initial begin
		wait (cases_loaded);
		#((10 + 4 * n_cases + 20) * 8);
		$display("run timed out before all cases completed");
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- ahb_async_sram_halfwidth.f
+incdir+verilog
verilog/ahb_pkg.sv
verilog/sram_pkg.sv
verilog/sram_access_fsm.sv
verilog/sram_data_lane.sv
verilog/sram_we_strobe.sv
verilog/ahb_async_sram_halfwidth.sv
bench/async_sram_model.sv
bench/tb_ahb_sram.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module tb_ahb_sram \
	-f ahb_async_sram_halfwidth.f -o sim_tb_ahb_sram \
	&& ./obj_dir/sim_tb_ahb_sram | tee /dev/stderr | grep -q "Simulation passed" \
	&& echo "run_sim: PASS" \
	|| { echo "run_sim: FAIL"; exit 1; }

//--- bench/sram_cases.txt
# op: 0 idle, 1 write, 2 read; size: 0 byte, 1 halfword, 2 word
# op addr size wdata expected_rdata (all hex)
1 00000100 1 0000beef 00000000
1 00000102 1 cafe0000 00000000
2 00000100 1 00000000 beefbeef
2 00000102 1 00000000 cafecafe
0 00000000 0 00000000 00000000
1 00000200 2 12345678 00000000
2 00000200 2 00000000 12345678
0 00000000 0 00000000 00000000
1 00000200 0 000000ab 00000000
1 00000203 0 cd000000 00000000
2 00000200 2 00000000 cd3456ab
1 00000201 0 0000ef00 00000000
2 00000202 1 00000000 cd34cd34
2 00000200 0 00000000 efabefab
0 00000000 0 00000000 00000000
1 00000300 2 a1b2c3d4 00000000
1 00000304 1 00001122 00000000
1 00000306 0 00330000 00000000
1 00000307 0 44000000 00000000
2 00000300 2 00000000 a1b2c3d4
2 00000304 2 00000000 44331122
0 00000000 0 00000000 00000000
2 00000306 1 00000000 44334433
1 00000100 2 0f1e2d3c 00000000
2 00000102 0 00000000 0f1e0f1e
2 00000100 2 00000000 0f1e2d3c
0 00000000 0 00000000 00000000
1 00000400 2 deadbeef 00000000
2 00000400 2 00000000 deadbeef
1 00000402 1 55660000 00000000
2 00000400 2 00000000 5566beef
2 00000401 0 00000000 beefbeef
0 00000000 0 00000000 00000000
